// ==== logic/rp_config.svh ====
////////////////////////////////////////////////////////////////////////////
// Board constants for the analog front-end
// Widths, channel count and housekeeping register map
// Pulled into the package and into any module that needs a constant
////////////////////////////////////////////////////////////////////////////

`ifndef RP_CONFIG_SVH
`define RP_CONFIG_SVH

`define RP_ADC_W          16            // ADC word, two LSBs unused on 14-bit parts
`define RP_DAC_W          14            // DAC word
`define RP_NUM_CH         2             // Channels per converter
`define RP_EXP_W          8             // Pins per expansion bank
`define RP_ADDR_W         8             // Register port address
`define RP_BUS_W          32            // Register port data

// Housekeeping register map, byte offsets
`define RP_REG_ID         8'h00
`define RP_REG_CTRL       8'h04         // [0] digital loop, [3:1] daisy mode
`define RP_REG_EXP_P_OUT  8'h08
`define RP_REG_EXP_P_DIR  8'h0C
`define RP_REG_EXP_N_OUT  8'h10
`define RP_REG_EXP_N_DIR  8'h14
`define RP_REG_EXP_P_IN   8'h18
`define RP_REG_EXP_N_IN   8'h1C

`define RP_HK_ID          32'h5250_0A01 // Read-only board ID

`endif

// ==== logic/rp_pkg.sv ====
////////////////////////////////////////////////////////////////////////////
// Shared types of the analog front-end
// Sample words, channel pairs, register port and expansion bank
////////////////////////////////////////////////////////////////////////////

`default_nettype none

`include "rp_config.svh"

package rp_pkg;

  ////////////////////////////////////////////////////////////////////////////
  // Sample words
  ////////////////////////////////////////////////////////////////////////////

  typedef logic        [`RP_ADC_W-1:0] adc_raw_t;   // Raw code, neg slope
  typedef logic signed [`RP_ADC_W-1:0] adc_smp_t;   // Two's complement ADC sample
  typedef logic signed [`RP_DAC_W-1:0] dac_smp_t;   // Two's complement DAC sample
  typedef logic        [`RP_DAC_W-1:0] dac_code_t;  // Offset binary, neg slope

  // Channel pairs, index is the channel number
  typedef adc_smp_t  [`RP_NUM_CH-1:0] adc_pair_t;
  typedef dac_smp_t  [`RP_NUM_CH-1:0] smp_pair_t;
  typedef dac_code_t [`RP_NUM_CH-1:0] dac_pair_t;

  ////////////////////////////////////////////////////////////////////////////
  // Register port
  ////////////////////////////////////////////////////////////////////////////

  typedef struct packed {
    logic                  wr;     // 1 = write, 0 = read
    logic [`RP_ADDR_W-1:0] addr;   // Byte offset
    logic [`RP_BUS_W-1:0]  wdata;
  } hk_req_t;

  typedef struct packed {
    logic [`RP_BUS_W-1:0]  rdata;
    logic                  err;    // Unmapped or read-only target
  } hk_rsp_t;

  ////////////////////////////////////////////////////////////////////////////
  // Housekeeping outputs
  ////////////////////////////////////////////////////////////////////////////

  typedef struct packed {
    logic [`RP_EXP_W-1:0]  dat;    // Pin drive value
    logic [`RP_EXP_W-1:0]  oe;     // 1 = pin is an output
  } exp_bank_t;

  typedef struct packed {
    logic                  digital_loop;  // DAC feeds ADC path
    logic [2:0]            daisy_mode;    // Trigger routing bits
  } hk_ctrl_t;

endpackage

`default_nettype wire

// ==== logic/adc_front.sv ====
////////////////////////////////////////////////////////////////////////////
// ADC front end
// Turns the negative-slope ADC code into two's complement, one register
// Digital loopback swaps in the saturated DAC value instead
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/10ps
`default_nettype none

`include "rp_config.svh"

module adc_front (
  input  wire logic              adc_clk,
  input  wire logic              rst_n_i,
  input  rp_pkg::adc_pair_t      adc_raw_i,   // Straight from the pins
  input  rp_pkg::hk_ctrl_t       ctrl_i,
  input  rp_pkg::smp_pair_t      dac_loop_i,  // Saturated DAC sum
  output rp_pkg::adc_pair_t      adc_dat_o
);

  localparam int unsigned PAD_W = `RP_ADC_W - `RP_DAC_W;  // Zero bits over loopback

  rp_pkg::adc_pair_t adc_nxt;

  // Per-channel conversion
  always_comb begin
    rp_pkg::adc_raw_t raw;
    for (int ch = 0; ch < `RP_NUM_CH; ch++) begin
      raw = rp_pkg::adc_raw_t'(adc_raw_i[ch]);
      if (ctrl_i.digital_loop)
        adc_nxt[ch] = {{PAD_W{1'b0}}, dac_loop_i[ch]};          // Loopback path
      else
        adc_nxt[ch] = {raw[`RP_ADC_W-1], ~raw[`RP_ADC_W-2:0]};  // Keep MSB, flip rest
    end
  end

  always_ff @(posedge adc_clk) begin
    if (!rst_n_i) begin
      adc_dat_o <= '0;
    end else begin
      adc_dat_o <= adc_nxt;
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // Checks
  ////////////////////////////////////////////////////////////////////////////

  // Output stays quiet for as long as reset is held
  a_rst_zero: assert property (@(posedge adc_clk) !rst_n_i |=> adc_dat_o == '0);

endmodule

`default_nettype wire

// ==== logic/dac_mixer.sv ====
////////////////////////////////////////////////////////////////////////////
// DAC mixer
// Generator plus controller sample per channel, clamped to 14 bits
// Output register holds negative-slope offset binary for the DAC pins
// The clamped two's complement value is also handed back for loopback
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/10ps
`default_nettype none

`include "rp_config.svh"

module dac_mixer (
  input  wire logic              adc_clk,
  input  wire logic              rst_n_i,
  input  rp_pkg::smp_pair_t      gen_dat_i,   // Generator, 14 bit
  input  rp_pkg::adc_pair_t      ctl_dat_i,   // Controller, 16 bit
  output rp_pkg::dac_pair_t      dac_dat_o,
  output rp_pkg::smp_pair_t      dac_loop_o   // Same cycle as the inputs
);

  localparam int unsigned SUM_W = `RP_DAC_W + 1;  // One guard bit for overflow

  logic [`RP_NUM_CH-1:0][SUM_W-1:0] sum;          // Truncated sums
  rp_pkg::smp_pair_t                sat;          // Clamped samples

  ////////////////////////////////////////////////////////////////////////////
  // Sum and saturation
  ////////////////////////////////////////////////////////////////////////////

  always_comb begin
    rp_pkg::adc_smp_t wide;
    for (int ch = 0; ch < `RP_NUM_CH; ch++) begin
      wide    = `RP_ADC_W'(gen_dat_i[ch]) + ctl_dat_i[ch];  // Sign extend generator
      sum[ch] = wide[SUM_W-1:0];                            // Upper bits dropped
      // Guard bit and sign disagree means overflow, pick the rail by sign
      if (sum[ch][SUM_W-1] ^ sum[ch][SUM_W-2])
        sat[ch] = {sum[ch][SUM_W-1], {(`RP_DAC_W-1){~sum[ch][SUM_W-1]}}};
      else
        sat[ch] = sum[ch][`RP_DAC_W-1:0];
    end
  end

  assign dac_loop_o = sat;

  // Output register, sign kept and magnitude bits flipped
  always_ff @(posedge adc_clk) begin
    if (!rst_n_i) begin
      for (int ch = 0; ch < `RP_NUM_CH; ch++) begin
        dac_dat_o[ch] <= {1'b0, {(`RP_DAC_W-1){1'b1}}};  // Code for zero
      end
    end else begin
      for (int ch = 0; ch < `RP_NUM_CH; ch++) begin
        dac_dat_o[ch] <= {sat[ch][`RP_DAC_W-1], ~sat[ch][`RP_DAC_W-2:0]};
      end
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // Checks
  ////////////////////////////////////////////////////////////////////////////

  // An overflowing sum reaches the pins as one of the two end codes
  for (genvar g = 0; g < `RP_NUM_CH; g++) begin : g_chk
    a_clamp: assert property (@(posedge adc_clk) disable iff (!rst_n_i)
      (sum[g][SUM_W-1] ^ sum[g][SUM_W-2]) |=>
        dac_dat_o[g] inside {{`RP_DAC_W{1'b0}}, {`RP_DAC_W{1'b1}}});
  end

endmodule

`default_nettype wire

// ==== logic/hk_regs.sv ====
////////////////////////////////////////////////////////////////////////////
// Housekeeping register bank
// Four-phase req/ack slave holding loopback, daisy mode and the expansion
// pin output and direction registers, plus read-back of the pin inputs
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/10ps
`default_nettype none

`include "rp_config.svh"

module hk_regs (
  input  wire logic                 adc_clk,
  input  wire logic                 rst_n_i,
  // Register port
  input  wire logic                 req_i,
  input  rp_pkg::hk_req_t           hk_req_i,
  output logic                      ack_o,
  output rp_pkg::hk_rsp_t           hk_rsp_o,   // Valid while ack_o high
  // Raw pin levels, asynchronous
  input  wire logic [`RP_EXP_W-1:0] exp_p_in_i,
  input  wire logic [`RP_EXP_W-1:0] exp_n_in_i,
  // Configuration out
  output rp_pkg::hk_ctrl_t          ctrl_o,
  output rp_pkg::exp_bank_t         exp_p_o,
  output rp_pkg::exp_bank_t         exp_n_o
);

  localparam int unsigned PAD_W = `RP_BUS_W - `RP_EXP_W;

  typedef enum logic {S_IDLE, S_ACK} state_t;

  state_t                          state;
  logic                            accept;      // Request taken this cycle
  logic [1:0][`RP_EXP_W-1:0]       p_sync;      // [1] is the safe copy
  logic [1:0][`RP_EXP_W-1:0]       n_sync;
  logic [`RP_BUS_W-1:0]            rd_dat;
  logic                            bad;         // Unmapped or read-only write
  rp_pkg::hk_ctrl_t                ctrl_r;
  rp_pkg::exp_bank_t               p_r;
  rp_pkg::exp_bank_t               n_r;
  rp_pkg::hk_rsp_t                 rsp_r;

  assign accept = (state == S_IDLE) && req_i;

  // Two-flop synchronizers for the pin inputs
  always_ff @(posedge adc_clk) begin
    p_sync <= {p_sync[0], exp_p_in_i};
    n_sync <= {n_sync[0], exp_n_in_i};
  end

  ////////////////////////////////////////////////////////////////////////////
  // Address decode
  ////////////////////////////////////////////////////////////////////////////

  always_comb begin
    rd_dat = '0;
    bad    = 1'b0;
    case (hk_req_i.addr)
      `RP_REG_ID:        begin rd_dat = `RP_HK_ID; bad = hk_req_i.wr; end
      `RP_REG_CTRL:      rd_dat = {{(`RP_BUS_W-4){1'b0}}, ctrl_r.daisy_mode, ctrl_r.digital_loop};
      `RP_REG_EXP_P_OUT: rd_dat = {{PAD_W{1'b0}}, p_r.dat};
      `RP_REG_EXP_P_DIR: rd_dat = {{PAD_W{1'b0}}, p_r.oe};
      `RP_REG_EXP_N_OUT: rd_dat = {{PAD_W{1'b0}}, n_r.dat};
      `RP_REG_EXP_N_DIR: rd_dat = {{PAD_W{1'b0}}, n_r.oe};
      `RP_REG_EXP_P_IN:  begin rd_dat = {{PAD_W{1'b0}}, p_sync[1]}; bad = hk_req_i.wr; end
      `RP_REG_EXP_N_IN:  begin rd_dat = {{PAD_W{1'b0}}, n_sync[1]}; bad = hk_req_i.wr; end
      default:           bad = 1'b1;
    endcase
  end

  ////////////////////////////////////////////////////////////////////////////
  // Handshake FSM and writable registers
  ////////////////////////////////////////////////////////////////////////////

  always_ff @(posedge adc_clk) begin
    if (!rst_n_i) begin
      state  <= S_IDLE;
      ctrl_r <= '0;
      p_r    <= '0;  // All pins inputs
      n_r    <= '0;
    end else begin
      if (accept)
        state <= S_ACK;
      else if ((state == S_ACK) && !req_i)
        state <= S_IDLE;             // Master let go, close the cycle
      // Writes land on the same edge that raises ack
      if (accept && hk_req_i.wr && !bad) begin
        case (hk_req_i.addr)
          `RP_REG_CTRL: begin
            ctrl_r.digital_loop <= hk_req_i.wdata[0];
            ctrl_r.daisy_mode   <= hk_req_i.wdata[3:1];
          end
          `RP_REG_EXP_P_OUT: p_r.dat <= hk_req_i.wdata[`RP_EXP_W-1:0];
          `RP_REG_EXP_P_DIR: p_r.oe  <= hk_req_i.wdata[`RP_EXP_W-1:0];
          `RP_REG_EXP_N_OUT: n_r.dat <= hk_req_i.wdata[`RP_EXP_W-1:0];
          `RP_REG_EXP_N_DIR: n_r.oe  <= hk_req_i.wdata[`RP_EXP_W-1:0];
          default: ;
        endcase
      end
    end
  end

  // Response captured with the request
  always_ff @(posedge adc_clk) begin
    if (accept) begin
      rsp_r.rdata <= rd_dat;
      rsp_r.err   <= bad;
    end
  end

  assign ack_o    = (state == S_ACK);
  assign hk_rsp_o = rsp_r;
  assign ctrl_o   = ctrl_r;
  assign exp_p_o  = p_r;
  assign exp_n_o  = n_r;

  // No acknowledge without a request the cycle before
  a_ack_req: assert property (@(posedge adc_clk) disable iff (!rst_n_i)
    $rose(ack_o) |-> $past(req_i));

  // Master keeps the request word steady until it is acknowledged
  a_req_stable: assert property (@(posedge adc_clk) disable iff (!rst_n_i)
    (req_i && !ack_o) |=> $stable(hk_req_i));

endmodule

`default_nettype wire

// ==== logic/exp_pin_mux.sv ====
////////////////////////////////////////////////////////////////////////////
// Expansion connector alternate functions
// Overrides register-driven pins with the trigger output in daisy mode
// and gates the external trigger input in pure combinational logic
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/10ps
`default_nettype none

`include "rp_config.svh"

module exp_pin_mux (
  input  rp_pkg::exp_bank_t         exp_p_i,     // From the register bank
  input  rp_pkg::exp_bank_t         exp_n_i,
  input  rp_pkg::hk_ctrl_t          ctrl_i,
  input  wire logic [`RP_EXP_W-1:0] exp_p_in_i,  // Raw p pin levels
  input  wire logic                 daisy_trig_i,
  input  wire logic                 scope_trig_i,
  input  wire logic                 asg_trig_i,
  output rp_pkg::exp_bank_t         exp_p_o,     // To the pad drivers
  output rp_pkg::exp_bank_t         exp_n_o,
  output logic                      trig_ext_o
);

  localparam int unsigned PAD_W = `RP_EXP_W - 1;

  logic                 trig_sel;   // Trigger sent out on n pin 0
  logic [`RP_EXP_W-1:0] n_alt;      // 1 = pin taken by alternate function
  logic [`RP_EXP_W-1:0] n_alt_dat;

  // Per pin select between register and alternate function
  function automatic rp_pkg::exp_bank_t alt_mux(
    input rp_pkg::exp_bank_t    regs,
    input logic [`RP_EXP_W-1:0] alt,
    input logic [`RP_EXP_W-1:0] alt_dat
  );
    rp_pkg::exp_bank_t res;
    res.dat = (alt & alt_dat) | (~alt & regs.dat);
    res.oe  = alt | regs.oe;                          // Alternate pins are forced outputs
    return res;
  endfunction

  assign trig_sel = ctrl_i.daisy_mode[2] ? asg_trig_i : scope_trig_i;

  // Only n pin 0 has an alternate use
  assign n_alt     = {{PAD_W{1'b0}}, ctrl_i.daisy_mode[1]};
  assign n_alt_dat = {{PAD_W{1'b0}}, trig_sel};

  assign exp_p_o = exp_p_i;                           // No alternates on bank p
  assign exp_n_o = alt_mux(exp_n_i, n_alt, n_alt_dat);

  // External trigger from p pin 0 is blocked while the daisy chain owns triggering
  assign trig_ext_o = exp_p_in_i[0] & ~(ctrl_i.daisy_mode[0] & daisy_trig_i);

endmodule

`default_nettype wire

// ==== logic/rp_analog_top.sv ====
////////////////////////////////////////////////////////////////////////////
// Analog front-end top level
// ADC conversion, DAC mixing, housekeeping registers and expansion pins
// All on adc_clk, register access through the req/ack port
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/10ps
`default_nettype none

`include "rp_config.svh"

module rp_analog_top (
  input  wire logic                 adc_clk,
  input  wire logic                 rst_n_i,
  // Converters
  input  rp_pkg::adc_pair_t         adc_raw_i,
  output rp_pkg::adc_pair_t         adc_dat_o,     // Two's complement samples
  input  rp_pkg::smp_pair_t         gen_dat_i,     // Generator samples
  input  rp_pkg::adc_pair_t         ctl_dat_i,     // Controller samples
  output rp_pkg::dac_pair_t         dac_dat_o,
  // Register port
  input  wire logic                 req_i,
  input  rp_pkg::hk_req_t           hk_req_i,
  output logic                      ack_o,
  output rp_pkg::hk_rsp_t           hk_rsp_o,
  // Expansion connector
  input  wire logic [`RP_EXP_W-1:0] exp_p_in_i,
  input  wire logic [`RP_EXP_W-1:0] exp_n_in_i,
  output rp_pkg::exp_bank_t         exp_p_o,
  output rp_pkg::exp_bank_t         exp_n_o,
  // Triggers
  input  wire logic                 daisy_trig_i,
  input  wire logic                 scope_trig_i,
  input  wire logic                 asg_trig_i,
  output logic                      trig_ext_o
);

  rp_pkg::hk_ctrl_t  hk_ctrl;    // Loopback and daisy mode
  rp_pkg::exp_bank_t exp_p_reg;  // Register view of the banks
  rp_pkg::exp_bank_t exp_n_reg;
  rp_pkg::smp_pair_t dac_loop;   // Clamped DAC value for loopback

  ////////////////////////////////////////////////////////////////////////////
  // Data path
  ////////////////////////////////////////////////////////////////////////////

  adc_front u_adc_front (
    .adc_clk    (adc_clk),
    .rst_n_i    (rst_n_i),
    .adc_raw_i  (adc_raw_i),
    .ctrl_i     (hk_ctrl),
    .dac_loop_i (dac_loop),
    .adc_dat_o  (adc_dat_o)
  );

  dac_mixer u_dac_mixer (
    .adc_clk    (adc_clk),
    .rst_n_i    (rst_n_i),
    .gen_dat_i  (gen_dat_i),
    .ctl_dat_i  (ctl_dat_i),
    .dac_dat_o  (dac_dat_o),
    .dac_loop_o (dac_loop)
  );

  ////////////////////////////////////////////////////////////////////////////
  // Housekeeping and pins
  ////////////////////////////////////////////////////////////////////////////

  hk_regs u_hk_regs (
    .adc_clk    (adc_clk),
    .rst_n_i    (rst_n_i),
    .req_i      (req_i),
    .hk_req_i   (hk_req_i),
    .ack_o      (ack_o),
    .hk_rsp_o   (hk_rsp_o),
    .exp_p_in_i (exp_p_in_i),
    .exp_n_in_i (exp_n_in_i),
    .ctrl_o     (hk_ctrl),
    .exp_p_o    (exp_p_reg),
    .exp_n_o    (exp_n_reg)
  );

  exp_pin_mux u_exp_pin_mux (
    .exp_p_i      (exp_p_reg),
    .exp_n_i      (exp_n_reg),
    .ctrl_i       (hk_ctrl),
    .exp_p_in_i   (exp_p_in_i),   // Raw levels, trigger path is not synchronized
    .daisy_trig_i (daisy_trig_i),
    .scope_trig_i (scope_trig_i),
    .asg_trig_i   (asg_trig_i),
    .exp_p_o      (exp_p_o),
    .exp_n_o      (exp_n_o),
    .trig_ext_o   (trig_ext_o)
  );

endmodule

`default_nettype wire

// ==== bench/tb_rp_analog_top.sv ====
////////////////////////////////////////////////////////////////////////////
// Testbench for the analog front-end top level
// Random and edge-case samples, register traffic and pin muxing, checked
// by assertions against a reference model built from the data path rules
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/10ps
`default_nettype none

`include "rp_config.svh"

module tb_rp_analog_top;

  localparam int N_PLAIN     = 1200;                                // Loopback off
  localparam int N_LOOP      = 800;                                 // Loopback on
  localparam int N_PINS      = 800;                                 // Spread over 8 daisy modes
  localparam int RUN_CYC     = 10 + N_PLAIN + N_LOOP + N_PINS + 200; // Reset and bus traffic
  localparam int TIMEOUT_CYC = RUN_CYC * 4 / 3;                     // About 4000

  logic                 adc_clk = 1'b0;
  logic                 rst_n;
  rp_pkg::adc_pair_t    adc_raw, adc_dat, ctl_dat, exp_adc;
  rp_pkg::smp_pair_t    gen_dat;
  rp_pkg::dac_pair_t    dac_dat, exp_dac;
  logic                 req, ack;
  rp_pkg::hk_req_t      hk_req;
  rp_pkg::hk_rsp_t      hk_rsp;
  logic [`RP_EXP_W-1:0] exp_p_in, exp_n_in;
  rp_pkg::exp_bank_t    exp_p, exp_n, p_sh, n_sh;               // Pins and register shadows
  logic                 daisy_trig, scope_trig, asg_trig, trig_ext;
  logic                 loop_sh, exp_valid;
  logic [2:0]           dm_sh;                                 // Daisy mode shadow
  int                   errors, sample_cycles, xfers, cycles;

  always #2 adc_clk = ~adc_clk;   // 4 ns period

  rp_analog_top DUT (
    .adc_clk      (adc_clk),
    .rst_n_i      (rst_n),
    .adc_raw_i    (adc_raw),
    .adc_dat_o    (adc_dat),
    .gen_dat_i    (gen_dat),
    .ctl_dat_i    (ctl_dat),
    .dac_dat_o    (dac_dat),
    .req_i        (req),
    .hk_req_i     (hk_req),
    .ack_o        (ack),
    .hk_rsp_o     (hk_rsp),
    .exp_p_in_i   (exp_p_in),
    .exp_n_in_i   (exp_n_in),
    .exp_p_o      (exp_p),
    .exp_n_o      (exp_n),
    .daisy_trig_i (daisy_trig),
    .scope_trig_i (scope_trig),
    .asg_trig_i   (asg_trig),
    .trig_ext_o   (trig_ext)
  );

  ////////////////////////////////////////////////////////////////////////////
  // Reference model
  ////////////////////////////////////////////////////////////////////////////

  // Sum wraps at 15 bits first and then clamps to the 14-bit range
  function automatic int sat_sum(input rp_pkg::dac_smp_t gen, input rp_pkg::adc_smp_t ctl);
    int s;
    s = (int'(gen) + int'(ctl)) & 32'h7FFF;
    if (s >= 16384)
      s = s - 32768;               // Back to signed 15 bit
    if (s > 8191)
      s = 8191;
    else if (s < -8192)
      s = -8192;
    return s;
  endfunction

  function automatic rp_pkg::exp_bank_t n_model(input rp_pkg::exp_bank_t regs,
                                                input logic [2:0] dm, input logic asg,
                                                input logic scope);
    rp_pkg::exp_bank_t m;
    m = regs;
    if (dm[1]) begin
      m.oe[0]  = 1'b1;             // Trigger output takes pin 0
      m.dat[0] = dm[2] ? asg : scope;
    end
    return m;
  endfunction

  // Expected data one cycle after the inputs
  always @(posedge adc_clk) begin
    int s;
    exp_valid <= rst_n;
    for (int ch = 0; ch < `RP_NUM_CH; ch++) begin
      s = sat_sum(gen_dat[ch], ctl_dat[ch]);
      exp_dac[ch] <= 14'(s) ^ 14'h1FFF;                         // Negative slope
      exp_adc[ch] <= loop_sh ? {2'b00, 14'(s)} : adc_raw[ch] ^ 16'h7FFF;
    end
  end

  task automatic report_mismatch(input string test, input logic [31:0] expected,
                                 input logic [31:0] actual);
    errors++;
    $display("[FAIL] %s: expected %h, actual %h", test, expected, actual);
  endtask

  task automatic report_error(input string what);
    errors++;
    $display("ERROR: %s", what);
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // Checks
  ////////////////////////////////////////////////////////////////////////////

  // Registered outputs are stable on the falling edge
  a_adc: assert property (@(negedge adc_clk) exp_valid |-> adc_dat == exp_adc)
    else report_mismatch("adc_dat", 32'(exp_adc), 32'(adc_dat));
  a_dac: assert property (@(negedge adc_clk) exp_valid |-> dac_dat == exp_dac)
    else report_mismatch("dac_dat", 32'(exp_dac), 32'(dac_dat));

  // Ack follows req by one cycle in both directions
  a_ack_up: assert property (@(posedge adc_clk) disable iff (!rst_n) req |=> ack)
    else report_error("ack_o did not rise or hold one cycle after req_i");
  a_ack_down: assert property (@(posedge adc_clk) disable iff (!rst_n) !req |=> !ack)
    else report_error("ack_o stayed high after req_i dropped");

  // Pin mux outputs are combinational
  a_exp_p: assert property (@(posedge adc_clk) disable iff (!rst_n) exp_p == p_sh)
    else report_mismatch("exp_p_o", 32'($sampled(p_sh)), 32'($sampled(exp_p)));
  a_exp_n: assert property (@(posedge adc_clk) disable iff (!rst_n)
    exp_n == n_model(n_sh, dm_sh, asg_trig, scope_trig))
    else report_mismatch("exp_n_o",
      32'(n_model($sampled(n_sh), $sampled(dm_sh), $sampled(asg_trig), $sampled(scope_trig))),
      32'($sampled(exp_n)));
  a_trig: assert property (@(posedge adc_clk) disable iff (!rst_n)
    trig_ext == (exp_p_in[0] && !(dm_sh[0] && daisy_trig)))
    else report_mismatch("trig_ext_o", 32'(!$sampled(trig_ext)), 32'($sampled(trig_ext)));

  ////////////////////////////////////////////////////////////////////////////
  // Register port
  ////////////////////////////////////////////////////////////////////////////

  // Only writable registers move the shadows
  task automatic update_shadow(input logic [7:0] addr, input logic [31:0] wdata);
    case (addr)
      `RP_REG_CTRL: begin
        loop_sh = wdata[0];
        dm_sh   = wdata[3:1];
      end
      `RP_REG_EXP_P_OUT: p_sh.dat = wdata[7:0];
      `RP_REG_EXP_P_DIR: p_sh.oe  = wdata[7:0];
      `RP_REG_EXP_N_OUT: n_sh.dat = wdata[7:0];
      `RP_REG_EXP_N_DIR: n_sh.oe  = wdata[7:0];
      default: ;
    endcase
  endtask

  task automatic hk_xfer(input logic wr, input logic [7:0] addr, input logic [31:0] wdata,
                         output rp_pkg::hk_rsp_t rsp);
    @(negedge adc_clk);
    hk_req.wr    = wr;
    hk_req.addr  = addr;
    hk_req.wdata = wdata;
    req          = 1'b1;
    @(negedge adc_clk);
    while (!ack) @(negedge adc_clk);
    rsp = hk_rsp;                  // Valid while ack is high
    if (wr)
      update_shadow(addr, wdata);  // Write landed with the ack edge
    req = 1'b0;
    @(negedge adc_clk);
    while (ack) @(negedge adc_clk);
    xfers++;
  endtask

  task automatic write_reg(input logic [7:0] addr, input logic [31:0] wdata);
    rp_pkg::hk_rsp_t rsp;
    hk_xfer(1'b1, addr, wdata, rsp);
    assert (!rsp.err) else report_error($sformatf("write to %h flagged an error", addr));
  endtask

  task automatic read_check(input string name, input logic [7:0] addr,
                            input logic [31:0] expected);
    rp_pkg::hk_rsp_t rsp;
    hk_xfer(1'b0, addr, '0, rsp);
    assert (!rsp.err) else report_error({name, " read flagged an error"});
    assert (rsp.rdata == expected) else report_mismatch(name, expected, rsp.rdata);
  endtask

  task automatic expect_error(input string name, input logic wr, input logic [7:0] addr);
    rp_pkg::hk_rsp_t rsp;
    hk_xfer(wr, addr, 32'hFFFF_FFFF, rsp);
    assert (rsp.err) else report_error({name, " did not set the error flag"});
  endtask

  task automatic check_registers();
    logic [7:0]  rw_regs [4] = '{`RP_REG_EXP_P_OUT, `RP_REG_EXP_P_DIR,
                                 `RP_REG_EXP_N_OUT, `RP_REG_EXP_N_DIR};
    logic [31:0] r;
    read_check("id", `RP_REG_ID, `RP_HK_ID);
    for (int i = 0; i < 4; i++) begin
      r = $urandom;
      write_reg(rw_regs[i], r);                                  // Upper bits ignored
      read_check($sformatf("readback %h", rw_regs[i]), rw_regs[i], {24'h0, r[7:0]});
    end
    @(negedge adc_clk);
    r        = $urandom;
    exp_p_in = r[7:0];
    exp_n_in = r[15:8];
    repeat (2) @(negedge adc_clk);                               // Through the sync flops
    read_check("exp_p_in", `RP_REG_EXP_P_IN, {24'h0, r[7:0]});
    read_check("exp_n_in", `RP_REG_EXP_N_IN, {24'h0, r[15:8]});
    expect_error("unmapped read", 1'b0, 8'h20);
    expect_error("unaligned write", 1'b1, 8'h06);
    expect_error("id write", 1'b1, `RP_REG_ID);
    expect_error("pin input write", 1'b1, `RP_REG_EXP_P_IN);
    read_check("id after write", `RP_REG_ID, `RP_HK_ID);         // Still untouched
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // Stimulus
  ////////////////////////////////////////////////////////////////////////////

  task automatic drive_random(input int n);
    logic [31:0] r;
    repeat (n) begin
      @(negedge adc_clk);
      for (int ch = 0; ch < `RP_NUM_CH; ch++) begin
        r           = $urandom;
        adc_raw[ch] = r[15:0];
        gen_dat[ch] = r[29:16];
        r           = $urandom;
        ctl_dat[ch] = r[31] ? r[15:0] : {{3{r[12]}}, r[12:0]};  // Half small and half full range
      end
      r          = $urandom;
      exp_p_in   = r[7:0];
      exp_n_in   = r[15:8];
      daisy_trig = r[16];
      scope_trig = r[17];
      asg_trig   = r[18];
      sample_cycles++;
    end
  endtask

  // Both rails plus wrap past 15 bits and the zero code
  task automatic drive_edges();
    int g_list [9] = '{8191, -8192, 8191, -8192, 8191, 0, 0, -1, 4096};
    int c_list [9] = '{1, -1, 8191, -8192, 16384, 0, -8192, 32767, -32768};
    for (int i = 0; i < 9; i++) begin
      @(negedge adc_clk);
      gen_dat[0] = 14'(g_list[i]);
      ctl_dat[0] = 16'(c_list[i]);
      gen_dat[1] = 14'(g_list[8-i]);
      ctl_dat[1] = 16'(c_list[8-i]);
      sample_cycles++;
    end
  endtask

  task automatic set_ctrl(input logic loop, input logic [2:0] dm);
    write_reg(`RP_REG_CTRL, {28'h0, dm, loop});
  endtask

  // Cycle limit
  always @(posedge adc_clk) begin
    cycles++;
    if (cycles >= TIMEOUT_CYC) begin
      $display("ERROR: run stopped after %0d cycles without finishing", cycles);
      $display("** FAIL **");
      $finish;
    end
  end

  initial begin
    void'($urandom(98));
    {errors, sample_cycles, xfers, cycles} = '0;
    rst_n      = 1'b0;
    req        = 1'b0;
    hk_req     = '0;
    adc_raw    = '0;
    gen_dat    = '0;
    ctl_dat    = '0;
    exp_p_in   = '0;
    exp_n_in   = '0;
    daisy_trig = 1'b0;
    scope_trig = 1'b0;
    asg_trig   = 1'b0;
    loop_sh    = 1'b0;
    dm_sh      = '0;
    p_sh       = '0;
    n_sh       = '0;
    repeat (10) @(negedge adc_clk);
    assert (adc_dat == '0) else report_mismatch("adc_dat in reset", 32'h0, 32'(adc_dat));
    assert (dac_dat == {2{14'h1FFF}})
      else report_mismatch("dac_dat in reset", 32'({2{14'h1FFF}}), 32'(dac_dat));
    assert (!ack && exp_p.oe == '0 && exp_n.oe == '0)
      else report_error("register bank not cleared by reset");
    rst_n = 1'b1;
    drive_random(N_PLAIN);
    drive_edges();
    check_registers();
    set_ctrl(1'b1, 3'd0);          // DAC sum into the ADC path
    drive_random(N_LOOP);
    drive_edges();
    for (int dm = 0; dm < 8; dm++) begin
      write_reg(`RP_REG_EXP_N_OUT, $urandom);
      write_reg(`RP_REG_EXP_N_DIR, $urandom);
      set_ctrl(1'b0, 3'(dm));
      drive_random(N_PINS / 8);
    end
    repeat (3) @(negedge adc_clk);
    $display("Summary: %0d errors, %0d sample cycles, %0d register transfers",
             errors, sample_cycles, xfers);
    if (errors == 0)
      $display("** PASS **");
    else
      $display("** FAIL **");
    $finish;
  end

endmodule

`default_nettype wire

// ==== sim.f ====
+incdir+logic
logic/rp_pkg.sv
logic/adc_front.sv
logic/dac_mixer.sv
logic/hk_regs.sv
logic/exp_pin_mux.sv
logic/rp_analog_top.sv
bench/tb_rp_analog_top.sv

// ==== Makefile ====
# Verilator build and run of the analog front-end testbench

VERILATOR ?= verilator
TOP       ?= tb_rp_analog_top
FILELIST  ?= sim.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -j 0

SIM_BIN := $(OBJ_DIR)/V$(TOP)
SOURCES := $(shell grep -v '^+' $(FILELIST)) $(wildcard logic/*.svh)

.PHONY: all compile run clean

all: run

compile: $(SIM_BIN)

$(SIM_BIN): $(FILELIST) $(SOURCES)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: compile
	$(SIM_BIN) | tee $(LOG)
	@grep -qx '\*\* PASS \*\*' $(LOG) || (echo "Simulation did not pass, see $(LOG)"; exit 1)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
